//--- hw/icache_pkg.sv
package icache_pkg;

	// geometry
	localparam int unsigned ADDR_W        = 32;
	localparam int unsigned BUS_W         = 32;
	localparam int unsigned LINE_W        = 64;
	localparam int unsigned IC_NUM_WAYS   = 2;
	localparam int unsigned IC_INDEX_W    = 8;
	localparam int unsigned IC_NUM_SETS   = 1 << IC_INDEX_W;
	localparam int unsigned IC_TAG_W      = 21;
	localparam int unsigned IC_LINE_BEATS = LINE_W / BUS_W;
	// counts 0 up to IC_LINE_BEATS inclusive
	localparam int unsigned IC_BEAT_CNT_W = $clog2(IC_LINE_BEATS + 1);

	typedef logic [IC_INDEX_W-1:0]  ic_index_t;
	typedef logic [IC_TAG_W-1:0]    ic_tag_t;
	typedef logic [LINE_W-1:0]      ic_line_t;
	typedef logic [IC_NUM_WAYS-1:0] ic_ways_t;
	typedef logic [BUS_W-1:0]       bus_word_t;

	// tag 31:11, set 10:3, word 2, byte 1:0
	typedef struct packed {
		ic_tag_t   tag;
		ic_index_t index;
		logic      word;
		logic [1:0] byte_off;
	} ic_addr_t;

	typedef enum logic [2:0] {
		SWEEP,
		IDLE,
		LOOKUP,
		FILL_REQ,
		FILL_WAIT,
		WRITE,
		RESP
	} ic_state_e;

endpackage

//--- hw/icache_ram_if.sv
`timescale 1ns/1ps

interface icache_ram_if;
	import icache_pkg::*;

	// request side
	logic      req;
	logic      write;
	ic_index_t index;
	ic_ways_t  ways;
	ic_tag_t   wtag;
	logic      wvalid;
	ic_line_t  wdata;

	// read data, one entry per way
	ic_tag_t  [IC_NUM_WAYS-1:0] rtag;
	ic_ways_t                   rvalid;
	ic_line_t [IC_NUM_WAYS-1:0] rdata;

	modport ctrl (output req, write, index, ways, wtag, wvalid, input wdata);

	modport fill (output wdata);

	modport ram (
		input  req, write, index, ways, wtag, wvalid, wdata,
		output rtag, rvalid, rdata
	);

	modport lookup (input rtag, rvalid, rdata);

endinterface

//--- hw/icache_ram.sv
`timescale 1ns/1ps

module icache_ram (
	input  logic      clk_i,
	input  logic      rst_ni,
	icache_ram_if.ram ram
);
	import icache_pkg::*;

	logic [IC_NUM_SETS-1:0] valid_q [IC_NUM_WAYS];
	ic_tag_t                tag_mem [IC_NUM_WAYS][IC_NUM_SETS];
	ic_line_t               data_mem [IC_NUM_WAYS][IC_NUM_SETS];

	logic rd_en;
	logic wr_en;

	assign rd_en = ram.req & ~ram.write;
	assign wr_en = ram.req & ram.write;

	// valid bits per way and set
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int w = 0; w < IC_NUM_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else if (wr_en) begin
			for (int w = 0; w < IC_NUM_WAYS; w++) begin
				if (ram.ways[w]) begin
					valid_q[w][ram.index] <= ram.wvalid;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		for (int w = 0; w < IC_NUM_WAYS; w++) begin
			if (wr_en && ram.ways[w]) begin
				tag_mem[w][ram.index]  <= ram.wtag;
				data_mem[w][ram.index] <= ram.wdata;
			end
			if (rd_en) begin
				ram.rtag[w]  <= tag_mem[w][ram.index];
				ram.rdata[w] <= data_mem[w][ram.index];
			end
		end
	end

	// registered valid read
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			ram.rvalid <= '0;
		end else if (rd_en) begin
			for (int w = 0; w < IC_NUM_WAYS; w++) begin
				ram.rvalid[w] <= valid_q[w][ram.index];
			end
		end
	end

	a_write_has_way: assert property (@(posedge clk_i) disable iff (!rst_ni)
		wr_en |-> ram.ways != '0);

endmodule

//--- hw/icache_lookup.sv
`timescale 1ns/1ps

module icache_lookup (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	icache_ram_if.lookup         ram,
	input  icache_pkg::ic_tag_t  lookup_tag_i,
	input  logic                 alloc_i,
	output logic                 hit_o,
	output icache_pkg::ic_line_t hit_line_o,
	output icache_pkg::ic_ways_t victim_o
);
	import icache_pkg::*;

	ic_ways_t match;
	ic_ways_t invalid;
	ic_ways_t lowest_invalid;
	ic_ways_t rr_q;

	// tag compare and hit line select
	always_comb begin
		match      = '0;
		hit_line_o = '0;
		for (int w = 0; w < IC_NUM_WAYS; w++) begin
			match[w] = ram.rvalid[w] && (ram.rtag[w] == lookup_tag_i);
			if (match[w]) begin
				hit_line_o = hit_line_o | ram.rdata[w];
			end
		end
	end

	assign hit_o = |match;

	assign invalid = ~ram.rvalid;
	// isolate lowest set bit
	assign lowest_invalid = invalid & (~invalid + ic_ways_t'(1));

	// prefer an empty way, else round robin
	assign victim_o = (|invalid) ? lowest_invalid : rr_q;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rr_q <= ic_ways_t'(1);
		end else if (alloc_i) begin
			rr_q <= {rr_q[IC_NUM_WAYS-2:0], rr_q[IC_NUM_WAYS-1]};
		end
	end

	// a set never holds the same line in two ways
	a_single_match: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$onehot0(match));

endmodule

//--- hw/icache_fill_buf.sv
`timescale 1ns/1ps

module icache_fill_buf (
	input  logic                                 clk_i,
	input  logic                                 rst_ni,
	icache_ram_if.fill                           ram,
	input  logic                                 start_i,
	input  logic                                 rvalid_i,
	input  icache_pkg::bus_word_t                rdata_i,
	input  logic                                 err_i,
	output icache_pkg::ic_line_t                 line_o,
	output logic [icache_pkg::IC_LINE_BEATS-1:0] err_o,
	output logic                                 done_o
);
	import icache_pkg::*;

	logic [IC_BEAT_CNT_W-1:0]             beat_cnt_q;
	logic [$clog2(IC_LINE_BEATS)-1:0]     beat_sel;
	logic [IC_LINE_BEATS-1:0]             err_q;
	bus_word_t [IC_LINE_BEATS-1:0]        line_q;

	assign beat_sel = beat_cnt_q[$clog2(IC_LINE_BEATS)-1:0];
	assign done_o   = beat_cnt_q == IC_BEAT_CNT_W'(IC_LINE_BEATS);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			beat_cnt_q <= '0;
			err_q      <= '0;
		end else if (start_i) begin
			beat_cnt_q <= '0;
			err_q      <= '0;
		end else if (rvalid_i) begin
			beat_cnt_q       <= beat_cnt_q + 1'b1;
			err_q[beat_sel]  <= err_q[beat_sel] | err_i;
		end
	end

	// beats arrive in order, beat 0 first
	always_ff @(posedge clk_i) begin
		if (rvalid_i) begin
			line_q[beat_sel] <= rdata_i;
		end
	end

	assign line_o    = line_q;
	assign ram.wdata = line_q;
	assign err_o     = err_q;

	a_no_extra_beat: assert property (@(posedge clk_i) disable iff (!rst_ni)
		rvalid_i |-> !done_o);

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
	input  logic                                 clk_i,
	input  logic                                 rst_ni,
	icache_ram_if.ctrl                           ram,
	input  logic                                 req_valid_i,
	output logic                                 req_ready_o,
	input  logic [icache_pkg::ADDR_W-1:0]        req_addr_i,
	output logic                                 resp_valid_o,
	input  logic                                 resp_ready_i,
	output icache_pkg::bus_word_t                resp_rdata_o,
	output logic                                 resp_err_o,
	output logic                                 instr_req_o,
	input  logic                                 instr_gnt_i,
	output logic [icache_pkg::ADDR_W-1:0]        instr_addr_o,
	input  logic                                 icache_enable_i,
	input  logic                                 icache_inval_i,
	output logic                                 busy_o,
	input  logic                                 hit_i,
	input  icache_pkg::ic_line_t                 hit_line_i,
	input  icache_pkg::ic_ways_t                 victim_i,
	input  icache_pkg::ic_line_t                 fill_line_i,
	input  logic [icache_pkg::IC_LINE_BEATS-1:0] fill_err_i,
	input  logic                                 fill_done_i,
	output icache_pkg::ic_tag_t                  lookup_tag_o,
	output logic                                 alloc_o,
	output logic                                 fill_start_o
);
	import icache_pkg::*;

	ic_state_e state_q;
	ic_state_e state_d;
	ic_index_t sweep_idx_q;
	logic      beat_q;
	ic_addr_t  req_addr;
	ic_addr_t  addr_q;
	ic_ways_t  victim_q;
	bus_word_t resp_rdata_q;
	logic      resp_err_q;
	logic      accept;
	logic      fill_ok;

	bus_word_t [IC_LINE_BEATS-1:0] hit_words;
	bus_word_t [IC_LINE_BEATS-1:0] fill_words;

	assign req_addr   = ic_addr_t'(req_addr_i);
	assign hit_words  = hit_line_i;
	assign fill_words = fill_line_i;

	// invalidate wins over a waiting request
	assign req_ready_o  = (state_q == IDLE) & ~icache_inval_i;
	assign accept       = req_valid_i & req_ready_o;
	assign busy_o       = state_q != IDLE;
	assign resp_valid_o = state_q == RESP;
	assign resp_rdata_o = resp_rdata_q;
	assign resp_err_o   = resp_err_q;
	assign instr_req_o  = state_q == FILL_REQ;
	assign instr_addr_o = {addr_q.tag, addr_q.index, beat_q, 2'b00};
	assign lookup_tag_o = addr_q.tag;

	// only clean lines are kept, and only while enabled
	assign fill_ok = icache_enable_i & ~|fill_err_i;

	always_comb begin
		state_d      = state_q;
		alloc_o      = 1'b0;
		fill_start_o = 1'b0;
		case (state_q)
			SWEEP: if (sweep_idx_q == '1) state_d = IDLE;
			IDLE: begin
				if (icache_inval_i) begin
					state_d = SWEEP;
				end else if (accept) begin
					state_d = LOOKUP;
				end
			end
			LOOKUP: begin
				if (hit_i && icache_enable_i) begin
					state_d = RESP;
				end else begin
					alloc_o      = 1'b1;
					fill_start_o = 1'b1;
					state_d      = FILL_REQ;
				end
			end
			FILL_REQ: if (instr_gnt_i && beat_q) state_d = FILL_WAIT;
			FILL_WAIT: if (fill_done_i) state_d = fill_ok ? WRITE : RESP;
			WRITE: state_d = RESP;
			RESP: if (resp_ready_i) state_d = IDLE;
			default: state_d = SWEEP;
		endcase
	end

	// tag and data RAM requests
	always_comb begin
		ram.req    = 1'b0;
		ram.write  = 1'b0;
		ram.index  = addr_q.index;
		ram.ways   = '1;
		ram.wtag   = addr_q.tag;
		ram.wvalid = 1'b0;
		case (state_q)
			SWEEP: begin
				ram.req   = 1'b1;
				ram.write = 1'b1;
				ram.index = sweep_idx_q;
				ram.wtag  = '0;
			end
			IDLE: begin
				ram.req   = accept;
				ram.index = req_addr.index;
			end
			WRITE: begin
				ram.req    = 1'b1;
				ram.write  = 1'b1;
				ram.ways   = victim_q;
				ram.wvalid = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q     <= SWEEP;
			sweep_idx_q <= '0;
			beat_q      <= 1'b0;
		end else begin
			state_q <= state_d;
			// wraps back to zero at the end of a sweep
			if (state_q == SWEEP) begin
				sweep_idx_q <= sweep_idx_q + 1'b1;
			end
			if (state_q == LOOKUP) begin
				beat_q <= 1'b0;
			end else if (instr_req_o && instr_gnt_i) begin
				beat_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			addr_q <= req_addr;
		end
		if (state_q == LOOKUP) begin
			victim_q     <= victim_i;
			resp_rdata_q <= hit_words[addr_q.word];
			resp_err_q   <= 1'b0;
		end
		if (state_q == FILL_WAIT && fill_done_i) begin
			resp_rdata_q <= fill_words[addr_q.word];
			resp_err_q   <= fill_err_i[addr_q.word];
		end
	end

	a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
		resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_rdata_o));

endmodule

//--- hw/icache_top.sv
`timescale 1ns/1ps

module icache_top (
	input  logic                          clk_i,
	input  logic                          rst_ni,
	input  logic                          req_valid_i,
	output logic                          req_ready_o,
	input  logic [icache_pkg::ADDR_W-1:0] req_addr_i,
	output logic                          resp_valid_o,
	input  logic                          resp_ready_i,
	output logic [icache_pkg::BUS_W-1:0]  resp_rdata_o,
	output logic                          resp_err_o,
	output logic                          instr_req_o,
	input  logic                          instr_gnt_i,
	output logic [icache_pkg::ADDR_W-1:0] instr_addr_o,
	input  logic                          instr_rvalid_i,
	input  logic [icache_pkg::BUS_W-1:0]  instr_rdata_i,
	input  logic                          instr_err_i,
	input  logic                          icache_enable_i,
	input  logic                          icache_inval_i,
	output logic                          busy_o
);
	import icache_pkg::*;

	logic                     hit;
	ic_line_t                 hit_line;
	ic_ways_t                 victim;
	ic_line_t                 fill_line;
	logic [IC_LINE_BEATS-1:0] fill_err;
	logic                     fill_done;
	ic_tag_t                  lookup_tag;
	logic                     alloc;
	logic                     fill_start;

	icache_ram_if ram_bus ();

	icache_ctrl u_ctrl (
		.clk_i, .rst_ni, .ram(ram_bus.ctrl),
		.req_valid_i, .req_ready_o, .req_addr_i,
		.resp_valid_o, .resp_ready_i, .resp_rdata_o, .resp_err_o,
		.instr_req_o, .instr_gnt_i, .instr_addr_o,
		.icache_enable_i, .icache_inval_i, .busy_o,
		.hit_i(hit), .hit_line_i(hit_line), .victim_i(victim),
		.fill_line_i(fill_line), .fill_err_i(fill_err), .fill_done_i(fill_done),
		.lookup_tag_o(lookup_tag), .alloc_o(alloc), .fill_start_o(fill_start)
	);

	icache_ram u_ram (.clk_i, .rst_ni, .ram(ram_bus.ram));

	icache_lookup u_lookup (
		.clk_i, .rst_ni, .ram(ram_bus.lookup),
		.lookup_tag_i(lookup_tag), .alloc_i(alloc),
		.hit_o(hit), .hit_line_o(hit_line), .victim_o(victim)
	);

	icache_fill_buf u_fill_buf (
		.clk_i, .rst_ni, .ram(ram_bus.fill),
		.start_i(fill_start), .rvalid_i(instr_rvalid_i),
		.rdata_i(instr_rdata_i), .err_i(instr_err_i),
		.line_o(fill_line), .err_o(fill_err), .done_o(fill_done)
	);

endmodule

//--- test/icache_bus_model.sv
`timescale 1ns/1ps

module icache_bus_model #(
	parameter logic [31:0] ERR_LO = 32'h0000_F000,
	parameter logic [31:0] ERR_HI = 32'h0000_FFFF,
	parameter int          DRV    = 2
) (
	input  logic        clk_i,
	input  logic        instr_req_i,
	input  logic [31:0] instr_addr_i,
	output logic        instr_gnt_o,
	output logic        instr_rvalid_o,
	output logic [31:0] instr_rdata_o,
	output logic        instr_err_o
);

	logic [15:0] lfsr;

	// galois form with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = (val << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic skip_cycles(input int n);
		repeat (n) begin
			@(posedge clk_i);
			#DRV;
		end
	endtask

	// one grant then a single rvalid per beat
	initial begin
		int          delay;
		logic [31:0] addr;
		lfsr           = 16'd49;
		instr_gnt_o    = 1'b0;
		instr_rvalid_o = 1'b0;
		instr_rdata_o  = '0;
		instr_err_o    = 1'b0;
		forever begin
			skip_cycles(1);
			instr_gnt_o    = 1'b0;
			instr_rvalid_o = 1'b0;
			if (instr_req_i) begin
				draw_bits(2, delay);
				skip_cycles(delay);
				addr        = instr_addr_i;
				instr_gnt_o = 1'b1;
				skip_cycles(1);
				instr_gnt_o = 1'b0;
				draw_bits(2, delay);
				skip_cycles(delay);
				// memory image is the inverted byte address
				instr_rvalid_o = 1'b1;
				instr_rdata_o  = ~addr;
				instr_err_o    = (addr >= ERR_LO) && (addr <= ERR_HI);
			end
		end
	end

endmodule

//--- test/tb_icache.sv
`timescale 1ns/1ps

module tb_icache;

	localparam int          HALF_PERIOD  = 20;
	localparam int          DRV          = 2;
	localparam int          RESET_CYCLES = 10;
	localparam int          SWEEP_TO     = 400;
	localparam int          HS_TO        = 200;
	localparam int          HIT_LAT      = 2;
	localparam int          STALL_CYCLES = 5;
	localparam logic [31:0] ERR_LO       = 32'h0000_F000;
	localparam logic [31:0] ERR_HI       = 32'h0000_FFFF;
	localparam logic [31:0] ADDR_A       = 32'h0000_1000;
	localparam logic [31:0] ERR_ADDR     = 32'h0000_F100;
	// set 1 with tags 4, 5 and 6
	localparam logic [31:0] SET_A        = 32'h0000_2008;
	localparam logic [31:0] SET_B        = 32'h0000_2808;
	localparam logic [31:0] SET_C        = 32'h0000_3008;
	localparam logic [31:0] FILLER       = 32'h0000_4010;
	// set 3 with tags 4 and 5
	localparam logic [31:0] SET_D        = 32'h0000_2018;
	localparam logic [31:0] SET_E        = 32'h0000_2818;

	logic        clk_i;
	logic        rst_ni;
	logic        req_valid_i;
	logic        req_ready_o;
	logic [31:0] req_addr_i;
	logic        resp_valid_o;
	logic        resp_ready_i;
	logic [31:0] resp_rdata_o;
	logic        resp_err_o;
	logic        instr_req_o;
	logic        instr_gnt_i;
	logic [31:0] instr_addr_o;
	logic        instr_rvalid_i;
	logic [31:0] instr_rdata_i;
	logic        instr_err_i;
	logic        icache_enable_i;
	logic        icache_inval_i;
	logic        busy_o;

	int gnt_count = 0;
	int miss_count = 0;

	icache_top dut0 (.*);

	icache_bus_model #(.ERR_LO(ERR_LO), .ERR_HI(ERR_HI), .DRV(DRV)) bus0 (
		.clk_i, .instr_req_i(instr_req_o), .instr_addr_i(instr_addr_o),
		.instr_gnt_o(instr_gnt_i), .instr_rvalid_o(instr_rvalid_i),
		.instr_rdata_o(instr_rdata_i), .instr_err_o(instr_err_i)
	);

	initial begin
		clk_i = 1'b0;
		forever #HALF_PERIOD clk_i = ~clk_i;
	end

	// counted mid-cycle away from the edges
	always @(negedge clk_i) begin
		if (rst_ni && instr_req_o && instr_gnt_i) begin
			gnt_count++;
		end
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[ERROR] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_i);
		#DRV;
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while (busy_o) begin
			next_cycle();
			t++;
			if (t > SWEEP_TO) begin
				fail_now("timeout: busy_o never fell after a sweep");
			end
		end
	endtask

	// lat counts edges from the accepting cycle to the first response cycle
	task automatic fetch(input logic [31:0] addr, input int exp_gnt, input int stall,
			output int lat);
		int          t;
		int          gnt_start;
		logic [31:0] held;
		gnt_start    = gnt_count;
		req_valid_i  = 1'b1;
		req_addr_i   = addr;
		resp_ready_i = (stall == 0);
		t = 0;
		while (!req_ready_o) begin
			next_cycle();
			t++;
			if (t > HS_TO) begin
				fail_now("timeout: fetch request was never accepted");
			end
		end
		lat = 0;
		do begin
			next_cycle();
			req_valid_i = 1'b0;
			lat++;
			if (lat > HS_TO) begin
				fail_now("timeout: no fetch response arrived");
			end
		end while (!resp_valid_o);
		check_value("resp_rdata_o", resp_rdata_o, ~addr);
		check_value("resp_err_o", 32'(resp_err_o), 32'(addr >= ERR_LO && addr <= ERR_HI));
		held = resp_rdata_o;
		repeat (stall) begin
			next_cycle();
			check_value("resp_valid_o", 32'(resp_valid_o), 32'd1);
			check_value("resp_rdata_o", resp_rdata_o, held);
			check_value("req_ready_o", 32'(req_ready_o), 32'd0);
		end
		resp_ready_i = 1'b1;
		next_cycle();
		check_value("instr_gnt_i count", gnt_count - gnt_start, exp_gnt);
		if (exp_gnt != 0) begin
			miss_count++;
		end
	endtask

	task automatic cold_miss();
		int lat;
		check_value("busy_o", 32'(busy_o), 32'd1);
		check_value("req_ready_o", 32'(req_ready_o), 32'd0);
		check_value("resp_valid_o", 32'(resp_valid_o), 32'd0);
		check_value("instr_req_o", 32'(instr_req_o), 32'd0);
		wait_idle();
		fetch(ADDR_A, 2, 0, lat);
	endtask

	task automatic repeat_hit();
		int lat;
		fetch(ADDR_A, 0, 0, lat);
		check_value("hit latency", lat, HIT_LAT);
		fetch(ADDR_A + 32'd4, 0, 0, lat);
		check_value("hit latency", lat, HIT_LAT);
	endtask

	task automatic way_replacement();
		int lat;
		// pointer turns on every miss so start from an even count
		if (miss_count % 2 != 0) begin
			fetch(FILLER, 2, 0, lat);
		end
		fetch(SET_A, 2, 0, lat);
		fetch(SET_B, 2, 0, lat);
		fetch(SET_C, 2, 0, lat);
		fetch(SET_B, 0, 0, lat);
		fetch(SET_A, 2, 0, lat);
		// second line takes the empty way although the pointer turned twice
		fetch(SET_D, 2, 0, lat);
		fetch(ERR_ADDR, 2, 0, lat);
		fetch(SET_E, 2, 0, lat);
		fetch(SET_D, 0, 0, lat);
	endtask

	task automatic inval_and_disable();
		int lat;
		icache_inval_i = 1'b1;
		next_cycle();
		icache_inval_i = 1'b0;
		check_value("busy_o", 32'(busy_o), 32'd1);
		wait_idle();
		fetch(ADDR_A, 2, 0, lat);
		icache_enable_i = 1'b0;
		fetch(ADDR_A, 2, 0, lat);
		fetch(ADDR_A + 32'd4, 2, 0, lat);
		icache_enable_i = 1'b1;
	endtask

	task automatic err_and_stall();
		int lat;
		fetch(ERR_ADDR, 2, 0, lat);
		fetch(ERR_ADDR, 2, 0, lat);
		fetch(ADDR_A, 0, STALL_CYCLES, lat);
		fetch(SET_C + 32'd4, 2, STALL_CYCLES, lat);
	endtask

	initial begin
		rst_ni          = 1'b0;
		req_valid_i     = 1'b0;
		req_addr_i      = '0;
		resp_ready_i    = 1'b1;
		icache_enable_i = 1'b1;
		icache_inval_i  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		#DRV;
		rst_ni = 1'b1;
		cold_miss();
		repeat_hit();
		way_replacement();
		inval_and_disable();
		err_and_stall();
		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- project.f
hw/icache_pkg.sv
hw/icache_ram_if.sv
hw/icache_ram.sv
hw/icache_lookup.sv
hw/icache_fill_buf.sv
hw/icache_ctrl.sv
hw/icache_top.sv
test/icache_bus_model.sv
test/tb_icache.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_icache -o sim_tb_icache
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_tb_icache 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
